/* src/sifh_pkg.sv */
package sifh_pkg;

    // default sizes, the top level overrides and passes them down
    // timestamp width
    parameter int TS_W = 8;
    // upper timestamp bits used by the coarse pass
    parameter int COARSE_W = 4;
    parameter int PIXELS = 4;
    // stamps per pixel per acquisition
    parameter int DATA_NUM = 4;
    parameter int ACQ_NUM = 3;
    // width of one bin count, counts wrap
    parameter int CNT_W = 8;

    // lower bits, also the bin address width within a pixel
    parameter int FINE_W = TS_W - COARSE_W;

    // cycles from the last accepted stamp until the peaks are settled
    // ram write, tracker compare, one spare cycle
    parameter int DRAIN_CYC = 3;

    // index width for a counter over n values, never below one bit
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // default pixel index width
    parameter int PIX_W = idx_w(PIXELS);

    // histogram pass, coarse first then fine
    typedef enum logic {
        PASS_COARSE = 1'b0,
        PASS_FINE   = 1'b1
    } pass_t;

    // sequencer states
    typedef enum logic [1:0] {
        SEQ_COUNT  = 2'd0,
        SEQ_DRAIN  = 2'd1,
        SEQ_REPORT = 2'd2
    } seq_state_t;

endpackage

/* src/hist_if.sv */
`timescale 1ns/1ps

interface hist_if #(
    parameter int PIXELS = sifh_pkg::PIXELS,
    parameter int FINE_W = sifh_pkg::FINE_W,
    parameter int CNT_W = sifh_pkg::CNT_W,
    localparam int PIX_W = sifh_pkg::idx_w(PIXELS)
);

    // request side, from the sequencer
    logic              upd_en;
    logic [PIX_W-1:0]  upd_pix;
    logic [FINE_W-1:0] upd_bin;

    // result side, one cycle after the request
    logic [CNT_W-1:0]  upd_cnt;
    logic              upd_cnt_valid;
    // pixel and bin the new count belongs to
    logic [PIX_W-1:0]  cnt_pix;
    logic [FINE_W-1:0] cnt_bin;

    modport issuer (
        output upd_en,
        output upd_pix,
        output upd_bin
    );

    modport memory (
        input  upd_en,
        input  upd_pix,
        input  upd_bin,
        output upd_cnt,
        output upd_cnt_valid,
        output cnt_pix,
        output cnt_bin
    );

    modport tracker (
        input upd_cnt,
        input upd_cnt_valid,
        input cnt_pix,
        input cnt_bin
    );

endinterface

/* src/acq_sequencer.sv */
`timescale 1ns/1ps

module acq_sequencer #(
    parameter int TS_W = sifh_pkg::TS_W,
    parameter int COARSE_W = sifh_pkg::COARSE_W,
    parameter int PIXELS = sifh_pkg::PIXELS,
    parameter int DATA_NUM = sifh_pkg::DATA_NUM,
    parameter int ACQ_NUM = sifh_pkg::ACQ_NUM,
    localparam int FINE_W = TS_W - COARSE_W,
    localparam int PIX_W = sifh_pkg::idx_w(PIXELS)
) (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  stamp_valid,
    input  logic [TS_W-1:0]       stamp,
    input  logic [COARSE_W-1:0]   coarse_peak,
    input  logic                  report_done,
    output logic                  ready,
    output sifh_pkg::pass_t       pass,
    output logic [PIX_W-1:0]      cur_pix,
    output logic                  pass_end,
    output logic                  clear_all,
    output logic                  report_start,
    hist_if.issuer                upd
);
    import sifh_pkg::*;

    localparam int STAMP_W = idx_w(DATA_NUM);
    localparam int ACQ_W = idx_w(ACQ_NUM);
    localparam int DRN_W = idx_w(DRAIN_CYC);

    seq_state_t          state;
    logic [STAMP_W-1:0]  stamp_cnt;
    logic [ACQ_W-1:0]    acq_cnt;
    logic [DRN_W-1:0]    drain_cnt;
    logic                accept;
    logic                last_stamp;
    logic                drain_done;
    logic                stamp_match;
    logic [COARSE_W-1:0] stamp_hi;
    logic [FINE_W-1:0]   stamp_lo;

    // stamps only count while counting
    assign ready = (state == SEQ_COUNT);
    assign accept = stamp_valid && ready;

    assign stamp_hi = stamp[TS_W-1 -: COARSE_W];
    assign stamp_lo = stamp[FINE_W-1:0];
    // fine pass keeps only stamps inside this pixel's coarse peak
    assign stamp_match = (stamp_hi == coarse_peak);

    // last stamp of the last pixel of the last acquisition
    assign last_stamp = (stamp_cnt == STAMP_W'(DATA_NUM - 1))
                     && (cur_pix == PIX_W'(PIXELS - 1))
                     && (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    assign drain_done = (state == SEQ_DRAIN) && (drain_cnt == DRN_W'(DRAIN_CYC - 1));

    // bin update, same cycle as the accept
    assign upd.upd_en = accept && ((pass == PASS_COARSE) || stamp_match);
    assign upd.upd_pix = cur_pix;
    assign upd.upd_bin = (pass == PASS_COARSE) ? FINE_W'(stamp_hi) : stamp_lo;

    // pipeline settled, tracker may copy or start reporting
    assign pass_end = drain_done;
    assign report_start = drain_done && (pass == PASS_FINE);
    // wipe bins before the fine pass and again after the report
    assign clear_all = (drain_done && (pass == PASS_COARSE))
                    || ((state == SEQ_REPORT) && report_done);

    // nested stamp, pixel and acquisition counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            stamp_cnt <= '0;
            cur_pix <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            if (stamp_cnt == STAMP_W'(DATA_NUM - 1)) begin
                stamp_cnt <= '0;
                if (cur_pix == PIX_W'(PIXELS - 1)) begin
                    cur_pix <= '0;
                    // wraps to zero on the last stamp of the pass
                    if (acq_cnt == ACQ_W'(ACQ_NUM - 1)) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    cur_pix <= cur_pix + 1'b1;
                end
            end else begin
                stamp_cnt <= stamp_cnt + 1'b1;
            end
        end
    end

    // pass control, drain and report handoff
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= SEQ_COUNT;
            pass <= PASS_COARSE;
            drain_cnt <= '0;
        end else begin
            case (state)
                SEQ_COUNT: begin
                    if (accept && last_stamp) begin
                        state <= SEQ_DRAIN;
                        drain_cnt <= '0;
                    end
                end
                SEQ_DRAIN: begin
                    if (drain_done) begin
                        // coarse goes straight on to fine
                        if (pass == PASS_COARSE) begin
                            state <= SEQ_COUNT;
                            pass <= PASS_FINE;
                        end else begin
                            state <= SEQ_REPORT;
                        end
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                SEQ_REPORT: begin
                    // tracker is on its last pixel
                    if (report_done) begin
                        state <= SEQ_COUNT;
                        pass <= PASS_COARSE;
                    end
                end
                default: begin
                    state <= SEQ_COUNT;
                end
            endcase
        end
    end

endmodule

/* src/bin_counter_ram.sv */
`timescale 1ns/1ps

module bin_counter_ram #(
    parameter int PIXELS = sifh_pkg::PIXELS,
    parameter int FINE_W = sifh_pkg::FINE_W,
    parameter int CNT_W = sifh_pkg::CNT_W
) (
    input  logic    clk,
    input  logic    combin_res,
    input  logic    clear_all,
    hist_if.memory  upd
);
    import sifh_pkg::*;

    // one histogram of 2^FINE_W bins per pixel
    localparam int BINS = 2 ** FINE_W;
    localparam int DEPTH = PIXELS * BINS;
    localparam int ADDR_W = idx_w(DEPTH);

    logic [CNT_W-1:0]  mem [DEPTH];
    // entry holds a count from this pass
    logic [DEPTH-1:0]  valid_q;
    logic [ADDR_W-1:0] addr;
    logic [CNT_W-1:0]  rd_cnt;
    logic              rd_valid;
    logic [CNT_W-1:0]  next_cnt;

    // pixel major layout
    assign addr = ADDR_W'(int'(upd.upd_pix) * BINS + int'(upd.upd_bin));

    // read is combinational, so a write on the previous edge
    // is already visible to a back to back hit on the same bin
    assign rd_cnt = mem[addr];
    assign rd_valid = valid_q[addr];

    // stale entry restarts at one, counts wrap
    assign next_cnt = rd_valid ? rd_cnt + 1'b1 : CNT_W'(1);

    always_ff @(posedge clk) begin
        if (upd.upd_en) begin
            mem[addr] <= next_cnt;
        end
    end

    // valid bits stand in for clearing the whole array
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid_q <= '0;
        end else if (clear_all) begin
            valid_q <= '0;
        end else if (upd.upd_en) begin
            valid_q[addr] <= 1'b1;
        end
    end

    // new count and where it went, one cycle after the request
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            upd.upd_cnt_valid <= 1'b0;
        end else begin
            upd.upd_cnt_valid <= upd.upd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.upd_en) begin
            upd.upd_cnt <= next_cnt;
            upd.cnt_pix <= upd.upd_pix;
            upd.cnt_bin <= upd.upd_bin;
        end
    end

endmodule

/* src/peak_tracker.sv */
`timescale 1ns/1ps

module peak_tracker #(
    parameter int PIXELS = sifh_pkg::PIXELS,
    parameter int COARSE_W = sifh_pkg::COARSE_W,
    parameter int FINE_W = sifh_pkg::FINE_W,
    parameter int CNT_W = sifh_pkg::CNT_W,
    localparam int PIX_W = sifh_pkg::idx_w(PIXELS)
) (
    input  logic                clk,
    input  logic                combin_res,
    input  sifh_pkg::pass_t     pass,
    input  logic [PIX_W-1:0]    cur_pix,
    input  logic                pass_end,
    input  logic                report_start,
    output logic [COARSE_W-1:0] coarse_peak,
    output logic                report_done,
    output logic                result_valid,
    output logic [PIX_W-1:0]    result_pixel,
    output logic [COARSE_W-1:0] result_coarse,
    output logic [FINE_W-1:0]   result_fine,
    hist_if.tracker             upd
);
    import sifh_pkg::*;

    // running maximum and its bin, per pixel
    logic [CNT_W-1:0]    max_cnt [PIXELS];
    logic [FINE_W-1:0]   max_bin [PIXELS];
    // coarse peak kept through the fine pass
    logic [COARSE_W-1:0] coarse_store [PIXELS];
    logic                new_max;
    logic                coarse_end;

    // strictly greater, so the first bin to reach a count keeps it
    assign new_max = upd.upd_cnt_valid && (upd.upd_cnt > max_cnt[upd.cnt_pix]);
    assign coarse_end = pass_end && (pass == PASS_COARSE);

    // fine pass gating reference for the sequencer
    assign coarse_peak = coarse_store[cur_pix];

    // last pixel on the result stream this cycle
    assign report_done = result_valid && (result_pixel == PIX_W'(PIXELS - 1));

    // stores do not move while reporting
    assign result_coarse = coarse_store[result_pixel];
    assign result_fine = max_bin[result_pixel];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXELS; i++) begin
                max_cnt[i] <= '0;
                max_bin[i] <= '0;
                coarse_store[i] <= '0;
            end
        end else if (report_done) begin
            // frame finished, back to an empty coarse pass
            for (int i = 0; i < PIXELS; i++) begin
                max_cnt[i] <= '0;
                max_bin[i] <= '0;
                coarse_store[i] <= '0;
            end
        end else if (coarse_end) begin
            // coarse winners become the fine pass window
            for (int i = 0; i < PIXELS; i++) begin
                coarse_store[i] <= COARSE_W'(max_bin[i]);
                max_cnt[i] <= '0;
                max_bin[i] <= '0;
            end
        end else if (new_max) begin
            max_cnt[upd.cnt_pix] <= upd.upd_cnt;
            max_bin[upd.cnt_pix] <= upd.cnt_bin;
        end
    end

    // result stream, one pixel per cycle from pixel 0
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            result_valid <= 1'b0;
            result_pixel <= '0;
        end else if (report_start) begin
            result_valid <= 1'b1;
            result_pixel <= '0;
        end else if (result_valid) begin
            if (report_done) begin
                result_valid <= 1'b0;
                result_pixel <= '0;
            end else begin
                result_pixel <= result_pixel + 1'b1;
            end
        end
    end

endmodule

/* src/tof_histogrammer_top.sv */
`timescale 1ns/1ps

module tof_histogrammer_top #(
    parameter int TS_W = sifh_pkg::TS_W,
    parameter int COARSE_W = sifh_pkg::COARSE_W,
    parameter int PIXELS = sifh_pkg::PIXELS,
    parameter int DATA_NUM = sifh_pkg::DATA_NUM,
    parameter int ACQ_NUM = sifh_pkg::ACQ_NUM,
    parameter int CNT_W = sifh_pkg::CNT_W,
    localparam int FINE_W = TS_W - COARSE_W,
    localparam int PIX_W = sifh_pkg::idx_w(PIXELS)
) (
    input  logic                clk,
    input  logic                combin_res,
    input  logic                stamp_valid,
    input  logic [TS_W-1:0]     stamp,
    output logic                ready,
    output sifh_pkg::pass_t     pass,
    output logic                result_valid,
    output logic [PIX_W-1:0]    result_pixel,
    output logic [COARSE_W-1:0] result_coarse,
    output logic [FINE_W-1:0]   result_fine
);

    // sequencer to tracker
    logic [PIX_W-1:0]    cur_pix;
    logic                pass_end;
    logic                report_start;
    // tracker back to sequencer
    logic [COARSE_W-1:0] coarse_peak;
    logic                report_done;
    // sequencer to bin memory
    logic                clear_all;

    // bin update path, sequencer to memory to tracker
    hist_if #(
        .PIXELS (PIXELS),
        .FINE_W (FINE_W),
        .CNT_W  (CNT_W)
    ) hist_bus ();

    acq_sequencer #(
        .TS_W     (TS_W),
        .COARSE_W (COARSE_W),
        .PIXELS   (PIXELS),
        .DATA_NUM (DATA_NUM),
        .ACQ_NUM  (ACQ_NUM)
    ) u_seq (
        .clk          (clk),
        .combin_res   (combin_res),
        .stamp_valid  (stamp_valid),
        .stamp        (stamp),
        .coarse_peak  (coarse_peak),
        .report_done  (report_done),
        .ready        (ready),
        .pass         (pass),
        .cur_pix      (cur_pix),
        .pass_end     (pass_end),
        .clear_all    (clear_all),
        .report_start (report_start),
        .upd          (hist_bus.issuer)
    );

    bin_counter_ram #(
        .PIXELS (PIXELS),
        .FINE_W (FINE_W),
        .CNT_W  (CNT_W)
    ) u_ram (
        .clk        (clk),
        .combin_res (combin_res),
        .clear_all  (clear_all),
        .upd        (hist_bus.memory)
    );

    peak_tracker #(
        .PIXELS   (PIXELS),
        .COARSE_W (COARSE_W),
        .FINE_W   (FINE_W),
        .CNT_W    (CNT_W)
    ) u_peak (
        .clk           (clk),
        .combin_res    (combin_res),
        .pass          (pass),
        .cur_pix       (cur_pix),
        .pass_end      (pass_end),
        .report_start  (report_start),
        .coarse_peak   (coarse_peak),
        .report_done   (report_done),
        .result_valid  (result_valid),
        .result_pixel  (result_pixel),
        .result_coarse (result_coarse),
        .result_fine   (result_fine),
        .upd           (hist_bus.tracker)
    );

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD = 40,
    parameter int RST_CYC = 2
) (
    output logic clk,
    output logic combin_res
);

    // free running clock, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // reset held over RST_CYC rising edges
    // released a quarter period later, away from both edges
    initial begin
        combin_res = 1'b0;
        repeat (RST_CYC) @(posedge clk);
        #(PERIOD / 4);
        combin_res = 1'b1;
    end

endmodule

/* tb/tof_histogrammer_tb.sv */
`timescale 1ns/1ps

module tof_histogrammer_tb;
    import sifh_pkg::*;

    // stamps in one pass, pixel by pixel inside each acquisition
    localparam int N_ST = PIXELS * DATA_NUM * ACQ_NUM;
    localparam int BINS = 2 ** FINE_W;
    localparam int TIMEOUT = 200;

    logic                clk;
    logic                combin_res;
    logic                stamp_valid;
    logic [TS_W-1:0]     stamp;
    logic                ready;
    pass_t               pass;
    logic                result_valid;
    logic [PIX_W-1:0]    result_pixel;
    logic [COARSE_W-1:0] result_coarse;
    logic [FINE_W-1:0]   result_fine;

    // stimulus of the current frame
    logic [TS_W-1:0]     coarse_st [N_ST];
    logic [TS_W-1:0]     fine_st [N_ST];
    // model results
    logic [COARSE_W-1:0] exp_coarse [PIXELS];
    logic [FINE_W-1:0]   exp_fine [PIXELS];
    int                  hist [PIXELS][BINS];
    int                  best [PIXELS];

    logic [31:0]         lcg_state;
    int                  value_errs;
    int                  proto_errs;
    // set on a timeout, skips the remaining tests
    bit                  aborted;

    clk_gen #(
        .PERIOD  (40),
        .RST_CYC (2)
    ) u_clk (
        .clk        (clk),
        .combin_res (combin_res)
    );

    tof_histogrammer_top UUT (
        .clk           (clk),
        .combin_res    (combin_res),
        .stamp_valid   (stamp_valid),
        .stamp         (stamp),
        .ready         (ready),
        .pass          (pass),
        .result_valid  (result_valid),
        .result_pixel  (result_pixel),
        .result_coarse (result_coarse),
        .result_fine   (result_fine)
    );

    // lcg, numerical recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [TS_W-1:0] rand_stamp();
        return TS_W'(next_random() >> 16);
    endfunction

    // where stamp k falls in the nested count
    function automatic int pix_of(input int k);
        return (k / DATA_NUM) % PIXELS;
    endfunction

    function automatic int acq_of(input int k);
        return k / (DATA_NUM * PIXELS);
    endfunction

    function automatic int slot_of(input int k);
        return k % DATA_NUM;
    endfunction

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_pass(input pass_t got, input pass_t exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED at %0d ns: %s is %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic compare_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            value_errs++;
            $display("FAILED at %0d ns: %s is %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic compare_result(
        input logic [PIX_W-1:0]    got_pix,
        input logic [COARSE_W-1:0] got_coarse,
        input logic [FINE_W-1:0]   got_fine,
        input logic [PIX_W-1:0]    exp_pix,
        input logic [COARSE_W-1:0] exp_c,
        input logic [FINE_W-1:0]   exp_f
    );
        if (got_pix !== exp_pix || got_coarse !== exp_c || got_fine !== exp_f) begin
            value_errs++;
            $display("FAILED at %0d ns: result pixel %0d coarse %0d fine %0d",
                     $time, got_pix, got_coarse, got_fine);
            $display("    expected pixel %0d coarse %0d fine %0d", exp_pix, exp_c, exp_f);
        end
    endtask

    task automatic clear_model();
        for (int p = 0; p < PIXELS; p++) begin
            best[p] = 0;
            for (int b = 0; b < BINS; b++) begin
                hist[p][b] = 0;
            end
        end
    endtask

    // coarse histogram of the upper bits
    // strictly greater, so the first bin to reach a count holds it
    task automatic model_coarse();
        int p;
        int b;
        clear_model();
        for (int i = 0; i < PIXELS; i++) begin
            exp_coarse[i] = '0;
        end
        for (int k = 0; k < N_ST; k++) begin
            p = pix_of(k);
            b = int'(coarse_st[k][TS_W-1 -: COARSE_W]);
            hist[p][b]++;
            if (hist[p][b] > best[p]) begin
                best[p] = hist[p][b];
                exp_coarse[p] = COARSE_W'(b);
            end
        end
    endtask

    // fine histogram, only stamps inside the pixel's coarse peak
    task automatic model_fine();
        int p;
        int b;
        clear_model();
        for (int i = 0; i < PIXELS; i++) begin
            exp_fine[i] = '0;
        end
        for (int k = 0; k < N_ST; k++) begin
            p = pix_of(k);
            if (fine_st[k][TS_W-1 -: COARSE_W] == exp_coarse[p]) begin
                b = int'(fine_st[k][FINE_W-1:0]);
                hist[p][b]++;
                if (hist[p][b] > best[p]) begin
                    best[p] = hist[p][b];
                    exp_fine[p] = FINE_W'(b);
                end
            end
        end
    endtask

    // idle inputs, or random strobes that the DUT must ignore
    task automatic drive_idle(input bit junk);
        stamp_valid = junk;
        stamp = junk ? rand_stamp() : '0;
    endtask

    // called on a falling edge, returns on the falling edge where ready is high
    task automatic wait_ready(input bit junk, output int waited);
        waited = 0;
        while (!ready && waited < TIMEOUT) begin
            drive_idle(junk);
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            proto_errs++;
            aborted = 1'b1;
            $display("timeout at %0d ns: ready stayed low for %0d cycles", $time, TIMEOUT);
        end
    endtask

    // one stamp per cycle while ready is high
    task automatic send_pass(input bit fine, input bit junk);
        int waited;
        for (int k = 0; k < N_ST; k++) begin
            wait_ready(junk, waited);
            if (aborted) begin
                return;
            end
            stamp_valid = 1'b1;
            stamp = fine ? fine_st[k] : coarse_st[k];
            @(negedge clk);
        end
        drive_idle(1'b0);
    endtask

    // drain, then PIXELS results in pixel order, then back to coarse
    task automatic check_results(input bit junk);
        int waited;
        waited = 0;
        while (!result_valid && waited < TIMEOUT) begin
            drive_idle(junk);
            @(negedge clk);
            waited++;
        end
        if (!result_valid) begin
            proto_errs++;
            aborted = 1'b1;
            $display("timeout at %0d ns: no result appeared after the fine pass", $time);
            return;
        end
        compare_cycles(waited, DRAIN_CYC, "fine drain length");
        for (int p = 0; p < PIXELS; p++) begin
            if (!result_valid) begin
                proto_errs++;
                $display("result stream stopped early at %0d ns, pixel %0d missing", $time, p);
            end else begin
                compare_result(result_pixel, result_coarse, result_fine,
                               PIX_W'(p), exp_coarse[p], exp_fine[p]);
            end
            drive_idle(junk);
            @(negedge clk);
        end
        compare_flag(result_valid, 1'b0, "result_valid after the last pixel");
        compare_flag(ready, 1'b1, "ready after the report");
        compare_pass(pass, PASS_COARSE, "pass after the report");
        drive_idle(1'b0);
    endtask

    // coarse pass, fine pass and report for the stamps in the arrays
    task automatic run_frame(input bit junk);
        int waited;
        model_coarse();
        model_fine();
        send_pass(1'b0, junk);
        if (aborted) begin
            return;
        end
        compare_flag(ready, 1'b0, "ready after the last coarse stamp");
        wait_ready(junk, waited);
        if (aborted) begin
            return;
        end
        compare_cycles(waited, DRAIN_CYC, "coarse drain length");
        compare_pass(pass, PASS_FINE, "pass after the coarse drain");
        send_pass(1'b1, junk);
        if (aborted) begin
            return;
        end
        compare_flag(ready, 1'b0, "ready after the last fine stamp");
        check_results(junk);
    endtask

    // dominant coarse and fine value per pixel, one background stamp in four
    task automatic fill_planted(input int base);
        int p;
        logic [COARSE_W-1:0] c;
        for (int k = 0; k < N_ST; k++) begin
            p = pix_of(k);
            c = COARSE_W'(3 * p + base);
            if (slot_of(k) == DATA_NUM - 1) begin
                coarse_st[k] = rand_stamp();
                fine_st[k] = rand_stamp();
            end else begin
                coarse_st[k] = {c, FINE_W'(next_random() >> 12)};
                fine_st[k] = {c, FINE_W'(5 * p + base)};
            end
        end
    endtask

    task automatic test_reset_state();
        compare_flag(ready, 1'b1, "ready after reset");
        compare_pass(pass, PASS_COARSE, "pass after reset");
        compare_flag(result_valid, 1'b0, "result_valid after reset");
        // nothing may come out without stamps
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            compare_flag(result_valid, 1'b0, "result_valid while idle");
            compare_flag(ready, 1'b1, "ready while idle");
        end
    endtask

    task automatic test_planted_peaks();
        fill_planted(5);
        run_frame(1'b0);
    endtask

    task automatic test_fine_gating();
        int p;
        logic [COARSE_W-1:0] c;
        for (int k = 0; k < N_ST; k++) begin
            coarse_st[k] = {COARSE_W'(2 * pix_of(k) + 1), FINE_W'(k)};
        end
        model_coarse();
        // outside stamps pile up on bin 9, they would win if counted
        // pixel 0 never gets a stamp inside its window
        for (int k = 0; k < N_ST; k++) begin
            p = pix_of(k);
            c = exp_coarse[p];
            if (p == 0 || slot_of(k) != DATA_NUM - 1) begin
                fine_st[k] = {~c, FINE_W'(9)};
            end else begin
                fine_st[k] = {c, FINE_W'(p + 1)};
            end
        end
        run_frame(1'b0);
    endtask

    task automatic test_repeat_and_tie();
        int p;
        int a;
        int s;
        bit pick_a;
        bit pick_y;
        // coarse runs A A B B, B B A A, A B B A: level at six, B got there first
        for (int k = 0; k < N_ST; k++) begin
            p = pix_of(k);
            a = acq_of(k);
            s = slot_of(k);
            pick_a = ((a == 0) && (s < 2)) || ((a == 1) && (s >= 2))
                  || ((a == 2) && (s == 0 || s == 3));
            coarse_st[k] = {pick_a ? COARSE_W'(p + 2) : COARSE_W'(p + 9), FINE_W'(s)};
        end
        model_coarse();
        // fine runs Y X X X, Y X X X, Y Y Y Y: level at six, X got there first
        for (int k = 0; k < N_ST; k++) begin
            p = pix_of(k);
            a = acq_of(k);
            s = slot_of(k);
            pick_y = ((s == 0) && (a < 2)) || (a == 2);
            fine_st[k] = {exp_coarse[p], pick_y ? FINE_W'(p + 7) : FINE_W'(p + 1)};
        end
        run_frame(1'b0);
    endtask

    task automatic test_ignored_strobes();
        fill_planted(2);
        // random strobes during every drain and the report
        run_frame(1'b1);
    endtask

    task automatic test_random_frames();
        int p;
        logic [31:0] r;
        for (int n = 0; n < 2; n++) begin
            for (int k = 0; k < N_ST; k++) begin
                coarse_st[k] = rand_stamp();
            end
            model_coarse();
            // about half the fine stamps inside the window
            for (int k = 0; k < N_ST; k++) begin
                p = pix_of(k);
                r = next_random();
                if (r[20]) begin
                    fine_st[k] = {exp_coarse[p], FINE_W'(r >> 24)};
                end else begin
                    fine_st[k] = rand_stamp();
                end
            end
            run_frame(1'b0);
            if (aborted) begin
                return;
            end
        end
    endtask

    initial begin
        int n;
        stamp_valid = 1'b0;
        stamp = '0;
        lcg_state = 32'h8cec_b7a2;
        value_errs = 0;
        proto_errs = 0;
        aborted = 1'b0;
        n = 0;
        // ends on a falling edge, where all driving happens
        while (combin_res !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (combin_res !== 1'b1) begin
            proto_errs++;
            aborted = 1'b1;
            $display("reset was never released");
        end
        if (!aborted) test_reset_state();
        if (!aborted) test_planted_peaks();
        if (!aborted) test_fine_gating();
        if (!aborted) test_repeat_and_tie();
        if (!aborted) test_ignored_strobes();
        if (!aborted) test_random_frames();
        $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
src/sifh_pkg.sv
src/hist_if.sv
src/acq_sequencer.sv
src/bin_counter_ram.sv
src/peak_tracker.sv
src/tof_histogrammer_top.sv
tb/clk_gen.sv
tb/tof_histogrammer_tb.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0
TOP        := tof_histogrammer_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
